// ==== src/xadc_pkg.sv ====
package xadc_pkg;

    //////////////////////////////////////////////////
    // widths and limits
    //////////////////////////////////////////////////
    localparam int RESULT_W            = 12;  // adc result
    localparam int CHAN_W              = 5;   // adc channel select
    localparam int SLOTS_PER_WORD      = 5;
    localparam int WORD_W              = 64;
    localparam int MAX_WORDS_PER_FRAME = 150; // words per udp frame
    localparam int ALL_CHANNELS_MIN    = 8;   // low nibble at or above this reads every chip
    localparam int NUM_VMM             = 8;

    typedef logic [RESULT_W-1:0] adc_result_t;
    typedef logic [CHAN_W-1:0]   adc_channel_t;
    typedef logic [2:0]          vmm_sel_t;
    typedef logic [10:0]         sample_count_t;
    typedef logic [17:0]         spacing_t;
    typedef logic [11:0]         word_count_t;
    typedef logic [WORD_W-1:0]   fifo_word_t;

    //////////////////////////////////////////////////
    // bundles between the blocks
    //////////////////////////////////////////////////
    typedef struct packed {
        logic         start;
        adc_channel_t channel;
    } conv_req_t;

    typedef struct packed {
        logic        done;
        adc_result_t result;
    } conv_rsp_t;

    typedef struct packed {
        logic     valid;
        vmm_sel_t vmm;
        logic     last;   // final sample of this chip
    } sample_req_t;

    typedef struct packed {
        logic        valid;
        vmm_sel_t    vmm;
        logic        last;
        adc_result_t result;
    } sample_t;

    typedef struct packed {
        logic       valid;
        logic       last;
        fifo_word_t data;
    } packed_word_t;

    typedef struct packed {
        logic        enable;
        logic        end_of_data;
        word_count_t len;
        fifo_word_t  data;
    } fifo_out_t;

    typedef enum logic [2:0] {
        idle,
        request,
        await_sample,
        spacing,
        await_flush,
        next_channel,
        await_release
    } seq_state_t;

endpackage

// ==== src/sample_sequencer.sv ====
`timescale 1ns/1ps

module sample_sequencer (
    input  logic                    clk200,
    input  logic                    rst,
    input  logic                    data_in_rdy,
    input  logic [15:0]             vmm_id,
    input  xadc_pkg::sample_count_t sample_size,
    input  xadc_pkg::spacing_t      delay_in,
    input  logic                    udp_done,
    input  xadc_pkg::sample_t       sample,
    input  logic                    run_done,
    output xadc_pkg::sample_req_t   sample_req,
    output logic                    xadc_busy
);
    import xadc_pkg::*;

    seq_state_t    state;
    logic          all_chans;   // step through every chip
    vmm_sel_t      vmm_sel;
    sample_count_t taken;       // requests issued for this chip
    sample_count_t taken_next;
    spacing_t      gap;

    assign taken_next = taken + 1'b1;

    //////////////////////////////////////////////////
    // run sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state      <= idle;
            all_chans  <= 1'b0;
            vmm_sel    <= '0;
            taken      <= '0;
            gap        <= '0;
            sample_req <= '0;
            xadc_busy  <= 1'b0;
        end
        else
        begin
            sample_req.valid <= 1'b0; // one-cycle request

            case (state)
                idle:
                begin
                    if (data_in_rdy)
                    begin
                        xadc_busy <= 1'b1;
                        taken     <= '0;
                        if (vmm_id[3:0] >= 4'(ALL_CHANNELS_MIN))
                        begin
                            all_chans <= 1'b1;
                            vmm_sel   <= '0; // all chips start at 0
                        end
                        else
                        begin
                            all_chans <= 1'b0;
                            vmm_sel   <= vmm_id[2:0];
                        end
                        state <= request;
                    end
                end

                request:
                begin
                    sample_req.valid <= 1'b1;
                    sample_req.vmm   <= vmm_sel;
                    sample_req.last  <= (taken_next >= sample_size);
                    taken            <= taken_next;
                    state            <= await_sample;
                end

                await_sample:
                begin
                    if (sample.valid)
                    begin
                        gap <= '0;
                        if (sample.last)
                            state <= await_flush; // let the partial word drain
                        else
                            state <= spacing;
                    end
                end

                // idle gap of delay_in+1 cycles
                spacing:
                begin
                    if (gap == delay_in)
                        state <= request;
                    else
                        gap <= gap + 1'b1;
                end

                await_flush:
                begin
                    if (run_done)
                        state <= next_channel;
                end

                next_channel:
                begin
                    taken <= '0;
                    if (all_chans && vmm_sel != vmm_sel_t'(NUM_VMM - 1))
                    begin
                        vmm_sel <= vmm_sel + 1'b1;
                        state   <= request;
                    end
                    else
                        state <= await_release;
                end

                // old command gone and udp frame sent
                await_release:
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== src/adc_conversion.sv ====
`timescale 1ns/1ps

module adc_conversion (
    input  logic                  clk200,
    input  logic                  rst,
    input  xadc_pkg::sample_req_t sample_req,
    input  xadc_pkg::conv_rsp_t   conv_rsp,
    output xadc_pkg::conv_req_t   conv_req,
    output xadc_pkg::sample_t     sample
);
    import xadc_pkg::*;

    logic         start_q;
    adc_channel_t chan_q;     // held until the adc answers
    vmm_sel_t     vmm_q;
    logic         last_q;

    logic         valid_q;
    adc_result_t  result_q;
    vmm_sel_t     sample_vmm_q;
    logic         sample_last_q;

    //////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////
    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            start_q <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            start_q <= sample_req.valid;
            valid_q <= conv_rsp.done;
        end
    end

    // request and result payload
    always_ff @(posedge clk200)
    begin
        if (sample_req.valid)
        begin
            chan_q <= {{(CHAN_W - 3){1'b0}}, sample_req.vmm}; // chip n on channel n
            vmm_q  <= sample_req.vmm;
            last_q <= sample_req.last;
        end
        if (conv_rsp.done)
        begin
            result_q      <= conv_rsp.result;
            sample_vmm_q  <= vmm_q;
            sample_last_q <= last_q;
        end
    end

    assign conv_req.start   = start_q;
    assign conv_req.channel = chan_q;

    assign sample.valid  = valid_q;
    assign sample.vmm    = sample_vmm_q;
    assign sample.last   = sample_last_q;
    assign sample.result = result_q;

endmodule

// ==== src/word_packer.sv ====
`timescale 1ns/1ps

module word_packer (
    input  logic                   clk200,
    input  logic                   rst,
    input  xadc_pkg::sample_t      sample,
    output xadc_pkg::packed_word_t packed_word
);
    import xadc_pkg::*;

    fifo_word_t acc;        // word being filled
    fifo_word_t fill;       // acc with the incoming result placed
    logic [2:0] slot;       // next free slot
    logic       slot_full;

    assign slot_full = (slot == 3'(SLOTS_PER_WORD - 1));

    //////////////////////////////////////////////////
    // slot placement
    //////////////////////////////////////////////////
    always_comb
    begin
        fill = acc;
        fill[RESULT_W * slot +: RESULT_W] = sample.result; // slot k at bit 12k
        fill[WORD_W-1 -: 4] = {1'b0, sample.vmm};          // header nibble
    end

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            acc         <= '0;
            slot        <= '0;
            packed_word <= '0;
        end
        else
        begin
            packed_word.valid <= 1'b0;

            if (sample.valid)
            begin
                if (slot_full || sample.last)
                begin
                    // emit and start over with an empty word
                    packed_word.valid <= 1'b1;
                    packed_word.last  <= sample.last;
                    packed_word.data  <= fill;
                    acc               <= '0;
                    slot              <= '0;
                end
                else
                begin
                    acc  <= fill;
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer (
    input  logic                   clk200,
    input  logic                   rst,
    input  xadc_pkg::packed_word_t packed_word,
    output xadc_pkg::fifo_out_t    fifo_out,
    output logic                   run_done
);
    import xadc_pkg::*;

    word_count_t frame_cnt;    // words already in this frame
    word_count_t cnt_next;
    logic        frame_end;

    assign cnt_next  = frame_cnt + 1'b1;
    assign frame_end = packed_word.last ||
                       (cnt_next == word_count_t'(MAX_WORDS_PER_FRAME));

    //////////////////////////////////////////////////
    // fifo write and frame counting
    //////////////////////////////////////////////////
    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            frame_cnt            <= '0;
            fifo_out.enable      <= 1'b0;
            fifo_out.end_of_data <= 1'b0;
            fifo_out.len         <= '0;
            run_done             <= 1'b0;
        end
        else
        begin
            fifo_out.enable <= 1'b0;
            run_done        <= 1'b0;

            if (packed_word.valid)
            begin
                fifo_out.enable      <= 1'b1;
                fifo_out.len         <= cnt_next; // count includes this word
                fifo_out.end_of_data <= frame_end;
                run_done             <= packed_word.last;
                if (frame_end)
                    frame_cnt <= '0;   // next frame
                else
                    frame_cnt <= cnt_next;
            end
            else if (fifo_out.enable)
                fifo_out.end_of_data <= fifo_out.end_of_data; // two cycles wide
            else
                fifo_out.end_of_data <= 1'b0;
        end
    end

    // word data follows the strobe
    always_ff @(posedge clk200)
    begin
        if (packed_word.valid)
            fifo_out.data <= packed_word.data;
    end

endmodule

// ==== src/xadc_sampler.sv ====
`timescale 1ns/1ps

module xadc_sampler (
    input  logic                   clk200,
    input  logic                   rst,
    input  logic                   data_in_rdy,
    input  logic [15:0]            vmm_id,
    input  xadc_pkg::sample_count_t sample_size,
    input  xadc_pkg::spacing_t     delay_in,
    input  logic                   udp_done,
    input  xadc_pkg::conv_rsp_t    conv_rsp,
    output xadc_pkg::conv_req_t    conv_req,
    output xadc_pkg::fifo_out_t    fifo_out,
    output logic                   xadc_busy
);
    import xadc_pkg::*;

    sample_req_t  sample_req;
    sample_t      sample;
    packed_word_t packed_word;
    logic         run_done;   // last word of a chip written

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    sample_sequencer u_sequencer (
        .clk200      (clk200),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .sample      (sample),
        .run_done    (run_done),
        .sample_req  (sample_req),
        .xadc_busy   (xadc_busy)
    );

    //////////////////////////////////////////////////
    // data path from adc to fifo
    //////////////////////////////////////////////////
    adc_conversion u_conversion (
        .clk200     (clk200),
        .rst        (rst),
        .sample_req (sample_req),
        .conv_rsp   (conv_rsp),
        .conv_req   (conv_req),
        .sample     (sample)
    );

    word_packer u_packer (
        .clk200      (clk200),
        .rst         (rst),
        .sample      (sample),
        .packed_word (packed_word)
    );

    frame_writer u_writer (
        .clk200      (clk200),
        .rst         (rst),
        .packed_word (packed_word),
        .fifo_out    (fifo_out),
        .run_done    (run_done)
    );

endmodule

// ==== dv/xadc_sampler_sva.sv ====
`timescale 1ns/1ps

module xadc_sampler_sva (
    input logic                 clk200,
    input logic                 rst,
    input xadc_pkg::conv_req_t  conv_req,
    input xadc_pkg::conv_rsp_t  conv_rsp,
    input xadc_pkg::fifo_out_t  fifo_out,
    input xadc_pkg::spacing_t   delay_in,
    input logic                 xadc_busy
);
    import xadc_pkg::*;

    logic        pending;       // start issued and not yet answered
    logic        seen_start;
    logic [19:0] since_start;   // saturating count of cycles since the previous start
    int          fail_count = 0; // failed assertions

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            pending     <= 1'b0;
            seen_start  <= 1'b0;
            since_start <= '0;
        end
        else
        begin
            if (conv_req.start)
                pending <= 1'b1;
            else if (conv_rsp.done)
                pending <= 1'b0;
            if (conv_req.start)
            begin
                seen_start  <= 1'b1;
                since_start <= 20'd1;
            end
            else if (since_start != '1)
                since_start <= since_start + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////
    a_one_outstanding: assert property (@(posedge clk200) disable iff (rst)
        conv_req.start |-> !pending)
    else
    begin
        $error("conversion started before the previous one was answered");
        fail_count++;
    end

    a_enable_gap: assert property (@(posedge clk200) disable iff (rst)
        fifo_out.enable |=> !fifo_out.enable ##1 !fifo_out.enable)
    else
    begin
        $error("fifo enable pulses closer than 3 cycles");
        fail_count++;
    end

    a_eod_width: assert property (@(posedge clk200) disable iff (rst)
        fifo_out.enable && fifo_out.end_of_data |=> fifo_out.end_of_data)
    else
    begin
        $error("end_of_data shorter than 2 cycles");
        fail_count++;
    end

    a_reset_idle: assert property (@(posedge clk200)
        rst |=> !xadc_busy && !conv_req.start && !fifo_out.enable)
    else
    begin
        $error("outputs active after reset");
        fail_count++;
    end

    a_start_spacing: assert property (@(posedge clk200) disable iff (rst)
        conv_req.start && seen_start |-> since_start > delay_in)
    else
    begin
        $error("conversion starts closer than delay_in+1 cycles");
        fail_count++;
    end

endmodule

bind xadc_sampler xadc_sampler_sva u_sva (.*);

// ==== dv/tb_xadc_sampler.sv ====
`timescale 1ns/1ps

module tb_xadc_sampler;
    import xadc_pkg::*;

    localparam int TOTAL_SAMPLES   = 10 + 7 + 3 * NUM_VMM + 755 + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 30 + 2000;

    logic          clk200 = 1'b0;
    logic          rst;
    logic          data_in_rdy;
    logic [15:0]   vmm_id;
    sample_count_t sample_size;
    spacing_t      delay_in;
    logic          udp_done;
    conv_rsp_t     conv_rsp = '0;
    conv_req_t     conv_req;
    fifo_out_t     fifo_out;
    logic          xadc_busy;

    integer        seed = 39827;
    int            req_cnt = 0;     // running request number
    int            errors = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;
    adc_result_t   res_q[$];
    adc_channel_t  chan_q[$];

    xadc_sampler uut (
        .clk200      (clk200),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .conv_rsp    (conv_rsp),
        .conv_req    (conv_req),
        .fifo_out    (fifo_out),
        .xadc_busy   (xadc_busy)
    );

    always #2 clk200 = ~clk200;

    task automatic tick();
        @(posedge clk200);
        #0.5;
    endtask

    // one line per failed check
    task automatic log_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // failures of this testbench and of the bound assertions
    function automatic int total_errors();
        return errors + uut.u_sva.fail_count;
    endfunction

    //////////////////////////////////////////////////
    // adc model answers every start once
    //////////////////////////////////////////////////
    always
    begin : adc_model
        int          lat;
        adc_result_t r;
        @(negedge clk200);
        if (conv_req.start === 1'b1)
        begin
            lat = 3 + ($unsigned($random(seed)) % 8);   // 3 to 10 cycles
            r   = adc_result_t'(req_cnt % 4096);
            req_cnt++;
            res_q.push_back(r);
            chan_q.push_back(conv_req.channel);
            repeat (lat) @(posedge clk200);
            #0.5 conv_rsp = {1'b1, r};
            @(posedge clk200);
            #0.5 conv_rsp.done = 1'b0;
        end
    end

    // expected word built from the queued results and compared on the enable cycle
    task automatic check_word(input string name, input int chip,
                              inout int remaining, inout int frame_cnt);
        fifo_word_t   exp_data;
        logic         exp_eod;
        adc_channel_t ch;
        int           n;
        n        = (remaining < SLOTS_PER_WORD) ? remaining : SLOTS_PER_WORD;
        exp_data = '0;
        do @(negedge clk200); while (fifo_out.enable !== 1'b1);
        assert (res_q.size() >= n)
            else log_error($sformatf("%s: fewer ADC results than the word needs", name));
        for (int k = 0; k < n; k++)
        begin
            ch = chan_q.pop_front();
            exp_data[RESULT_W * k +: RESULT_W] = res_q.pop_front();
            assert (ch == adc_channel_t'(chip))
                else log_error($sformatf("error %s channel expected %0d actual %0d",
                                         name, chip, ch));
        end
        exp_data[WORD_W-1 -: 4] = 4'(chip);   // zero bit then chip index
        remaining -= n;
        frame_cnt++;
        exp_eod = (remaining == 0) || (frame_cnt == MAX_WORDS_PER_FRAME);
        assert (fifo_out.data === exp_data)
            else log_error($sformatf("error %s data expected %h actual %h",
                                     name, exp_data, fifo_out.data));
        assert (fifo_out.len === word_count_t'(frame_cnt))
            else log_error($sformatf("error %s len expected %0d actual %0d",
                                     name, frame_cnt, fifo_out.len));
        assert (fifo_out.end_of_data === exp_eod)
            else log_error($sformatf("error %s end_of_data expected %b actual %b",
                                     name, exp_eod, fifo_out.end_of_data));
        if (exp_eod)
            frame_cnt = 0;
        @(negedge clk200);   // second cycle of end_of_data
        assert (fifo_out.end_of_data === exp_eod)
            else log_error($sformatf("error %s held end_of_data expected %b actual %b",
                                     name, exp_eod, fifo_out.end_of_data));
    endtask

    task automatic report(input string name, input int err0);
        if (total_errors() == err0)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, total_errors() - err0);
        end
    endtask

    // hold_rdy keeps data_in_rdy high with udp_done already high
    task automatic run_test(input string name, input logic [15:0] sel, input int size,
                            input int gap, input bit hold_rdy);
        int first;
        int last;
        int remaining;
        int frame_cnt;
        int err0;
        int wait_cnt;
        err0      = total_errors();
        first     = (sel[3:0] >= ALL_CHANNELS_MIN) ? 0 : sel[2:0];
        last      = (sel[3:0] >= ALL_CHANNELS_MIN) ? NUM_VMM - 1 : first;
        frame_cnt = 0;
        tick();
        vmm_id      = sel;
        sample_size = sample_count_t'(size);
        delay_in    = spacing_t'(gap);
        udp_done    = hold_rdy;
        data_in_rdy = 1'b1;
        tick();
        data_in_rdy = hold_rdy;
        @(negedge clk200);
        assert (xadc_busy === 1'b1)
            else log_error($sformatf("%s: busy did not rise after the ready strobe", name));
        for (int chip = first; chip <= last; chip++)
        begin
            remaining = size;
            while (remaining > 0)
                check_word(name, chip, remaining, frame_cnt);
        end
        repeat (5) @(negedge clk200);
        assert (xadc_busy === 1'b1)
            else log_error($sformatf("%s: busy fell before the release condition", name));
        tick();
        data_in_rdy = 1'b0;
        udp_done    = 1'b1;
        wait_cnt    = 0;
        while (xadc_busy === 1'b1 && wait_cnt < 10)
        begin
            @(negedge clk200);
            wait_cnt++;
        end
        assert (xadc_busy === 1'b0)
            else log_error($sformatf("%s: busy did not fall after release", name));
        tick();
        udp_done = 1'b0;
        assert (res_q.size() == 0)
            else log_error($sformatf("%s: ADC results left over after the run", name));
        report(name, err0);
    endtask

    task automatic reset_check(input string name);
        int err0;
        err0 = total_errors();
        tick();
        rst = 1'b1;
        repeat (3) tick();
        rst = 1'b0;
        @(negedge clk200);
        assert (conv_req.start === 1'b0 && fifo_out.enable === 1'b0 && xadc_busy === 1'b0 &&
                fifo_out.end_of_data === 1'b0 && fifo_out.len === '0)
            else log_error($sformatf("%s: outputs active after reset", name));
        report(name, err0);
    endtask

    initial
    begin
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b0;
        repeat (3) @(posedge clk200);
        #0.5 rst = 1'b0;

        run_test("single_chip", 16'h0003, 10, 20, 1'b0);
        run_test("partial_word", 16'h0006, 7, 3, 1'b0);
        run_test("all_chips", 16'h0009, 3, 1, 1'b0);
        run_test("frame_limit", 16'h0002, 755, 0, 1'b0);
        run_test("busy_release", 16'h0005, 4, 2, 1'b1);
        reset_check("reset_idle");

        $display("tests passed %0d failed %0d assertion failures %0d",
                 tests_passed, tests_failed, uut.u_sva.fail_count);
        if (tests_failed == 0 && total_errors() == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * 4);
        $display("timeout, the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== xadc_sampler.f ====
src/xadc_pkg.sv
src/sample_sequencer.sv
src/adc_conversion.sv
src/word_packer.sv
src/frame_writer.sv
src/xadc_sampler.sv
dv/xadc_sampler_sva.sv
dv/tb_xadc_sampler.sv
